// File: Bender.yml
package:
  name: cr_subsystem

sources:
  # RTL, packages first
  - files:
      - logic/cr_map_pkg.sv
      - logic/kbd_pkg.sv
      - logic/kbd_ps2_rx.sv
      - logic/kbd_fifo.sv
      - logic/cr_mem.sv
      - logic/cr_subsystem_top.sv

  # Verification
  - target: any(simulation, test)
    files:
      - verification/cr_subsystem_assert.sv
      - verification/cr_subsystem_tb.sv

// File: logic/cr_map_pkg.sv
`default_nettype none

package cr_map_pkg;

    // ----------------------------------------------------------
    // Bus and field types
    // ----------------------------------------------------------
    typedef logic [31:0] cr_addr_t;
    typedef logic [31:0] cr_data_t;
    typedef logic [7:0]  seg7_t;
    typedef logic [9:0]  led_t;
    typedef logic [9:0]  switch_t;
    typedef logic [11:0] joy_t;

    // ----------------------------------------------------------
    // Register offsets
    // ----------------------------------------------------------
    // Read/write from the core
    localparam cr_addr_t CR_SEG7_0       = 32'h00;
    localparam cr_addr_t CR_SEG7_1       = 32'h04;
    localparam cr_addr_t CR_SEG7_2       = 32'h08;
    localparam cr_addr_t CR_SEG7_3       = 32'h0C;
    localparam cr_addr_t CR_SEG7_4       = 32'h10;
    localparam cr_addr_t CR_SEG7_5       = 32'h14;
    localparam cr_addr_t CR_LED          = 32'h18;
    localparam cr_addr_t CR_KBD_SCANF_EN = 32'h1C;

    // Read only, driven by the board
    localparam cr_addr_t CR_BUTTON_0     = 32'h20;
    localparam cr_addr_t CR_BUTTON_1     = 32'h24;
    localparam cr_addr_t CR_SWITCH       = 32'h28;
    localparam cr_addr_t CR_JOYSTICK_X   = 32'h2C;
    localparam cr_addr_t CR_JOYSTICK_Y   = 32'h30;

    // Keyboard status and data
    localparam cr_addr_t CR_KBD_READY    = 32'h34;
    localparam cr_addr_t CR_KBD_DATA     = 32'h38;

endpackage

`default_nettype wire

// File: logic/cr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cr_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    // Core port A
    input  cr_map_pkg::cr_addr_t address,
    input  cr_map_pkg::cr_data_t data,
    input  logic                 wren,
    input  logic                 rden,
    output cr_map_pkg::cr_data_t q,
    // Fabric port B
    input  cr_map_pkg::cr_addr_t address_b,
    output cr_map_pkg::cr_data_t q_b,
    // Board inputs
    input  logic                 button_0,
    input  logic                 button_1,
    input  cr_map_pkg::switch_t  switch_in,
    input  cr_map_pkg::joy_t     joystick_x,
    input  cr_map_pkg::joy_t     joystick_y,
    // Board outputs
    output cr_map_pkg::seg7_t    seg7_0,
    output cr_map_pkg::seg7_t    seg7_1,
    output cr_map_pkg::seg7_t    seg7_2,
    output cr_map_pkg::seg7_t    seg7_3,
    output cr_map_pkg::seg7_t    seg7_4,
    output cr_map_pkg::seg7_t    seg7_5,
    output cr_map_pkg::led_t     led,
    // Keyboard queue
    input  logic                 kbd_ready,
    input  kbd_pkg::kbd_byte_t   kbd_head,
    output logic                 kbd_scanf_en,
    output logic                 kbd_pop
);

    // Read/write registers and their two reflect stages
    cr_map_pkg::seg7_t   seg_reg [6];
    cr_map_pkg::seg7_t   seg_rfl [6];
    cr_map_pkg::seg7_t   seg_pin [6];
    cr_map_pkg::led_t    led_reg;
    cr_map_pkg::led_t    led_rfl;

    // Input synchronizer stages
    logic                btn0_s1;
    logic                btn0_s2;
    logic                btn1_s1;
    logic                btn1_s2;
    cr_map_pkg::switch_t sw_s1;
    cr_map_pkg::switch_t sw_s2;
    cr_map_pkg::joy_t    joyx_s1;
    cr_map_pkg::joy_t    joyx_s2;
    cr_map_pkg::joy_t    joyy_s1;
    cr_map_pkg::joy_t    joyy_s2;

    // Keyboard status copy
    logic                kbd_rdy_r;
    kbd_pkg::kbd_byte_t  kbd_data_r;

    cr_map_pkg::cr_data_t pre_q;
    cr_map_pkg::cr_data_t pre_q_b;

    // ----------------------------------------------------------
    // Core writes
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 6; i++) begin
                seg_reg[i] <= '0;
            end
            led_reg      <= '0;
            kbd_scanf_en <= 1'b0;
        end else if (wren) begin
            case (address)
                cr_map_pkg::CR_SEG7_0:       seg_reg[0]   <= data[7:0];
                cr_map_pkg::CR_SEG7_1:       seg_reg[1]   <= data[7:0];
                cr_map_pkg::CR_SEG7_2:       seg_reg[2]   <= data[7:0];
                cr_map_pkg::CR_SEG7_3:       seg_reg[3]   <= data[7:0];
                cr_map_pkg::CR_SEG7_4:       seg_reg[4]   <= data[7:0];
                cr_map_pkg::CR_SEG7_5:       seg_reg[5]   <= data[7:0];
                cr_map_pkg::CR_LED:          led_reg      <= data[9:0];
                cr_map_pkg::CR_KBD_SCANF_EN: kbd_scanf_en <= data[0];
                // Read-only and unmapped offsets ignore writes
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Output reflect and input sync
    // ----------------------------------------------------------
    // Register -> reflect -> pin
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 6; i++) begin
                seg_rfl[i] <= '0;
                seg_pin[i] <= '0;
            end
            led_rfl <= '0;
            led     <= '0;
        end else begin
            seg_rfl <= seg_reg;
            seg_pin <= seg_rfl;
            led_rfl <= led_reg;
            led     <= led_rfl;
        end
    end

    assign seg7_0 = seg_pin[0];
    assign seg7_1 = seg_pin[1];
    assign seg7_2 = seg_pin[2];
    assign seg7_3 = seg_pin[3];
    assign seg7_4 = seg_pin[4];
    assign seg7_5 = seg_pin[5];

    // Pins are asynchronous to clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn0_s1 <= 1'b0;
            btn0_s2 <= 1'b0;
            btn1_s1 <= 1'b0;
            btn1_s2 <= 1'b0;
            sw_s1   <= '0;
            sw_s2   <= '0;
            joyx_s1 <= '0;
            joyx_s2 <= '0;
            joyy_s1 <= '0;
            joyy_s2 <= '0;
        end else begin
            btn0_s1 <= button_0;
            btn0_s2 <= btn0_s1;
            btn1_s1 <= button_1;
            btn1_s2 <= btn1_s1;
            sw_s1   <= switch_in;
            sw_s2   <= sw_s1;
            joyx_s1 <= joystick_x;
            joyx_s2 <= joyx_s1;
            joyy_s1 <= joystick_y;
            joyy_s2 <= joyy_s1;
        end
    end

    // Keyboard status sampled every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kbd_rdy_r  <= 1'b0;
            kbd_data_r <= '0;
        end else begin
            kbd_rdy_r  <= kbd_ready;
            kbd_data_r <= kbd_head;
        end
    end

    // ----------------------------------------------------------
    // Read decode
    // ----------------------------------------------------------
    // Shared by both ports, zero extended, unmapped reads 0
    function automatic cr_map_pkg::cr_data_t read_word(input cr_map_pkg::cr_addr_t addr);
        cr_map_pkg::cr_data_t word;
        word = '0;
        case (addr)
            cr_map_pkg::CR_SEG7_0:       word = {24'b0, seg_reg[0]};
            cr_map_pkg::CR_SEG7_1:       word = {24'b0, seg_reg[1]};
            cr_map_pkg::CR_SEG7_2:       word = {24'b0, seg_reg[2]};
            cr_map_pkg::CR_SEG7_3:       word = {24'b0, seg_reg[3]};
            cr_map_pkg::CR_SEG7_4:       word = {24'b0, seg_reg[4]};
            cr_map_pkg::CR_SEG7_5:       word = {24'b0, seg_reg[5]};
            cr_map_pkg::CR_LED:          word = {22'b0, led_reg};
            cr_map_pkg::CR_KBD_SCANF_EN: word = {31'b0, kbd_scanf_en};
            cr_map_pkg::CR_BUTTON_0:     word = {31'b0, btn0_s2};
            cr_map_pkg::CR_BUTTON_1:     word = {31'b0, btn1_s2};
            cr_map_pkg::CR_SWITCH:       word = {22'b0, sw_s2};
            cr_map_pkg::CR_JOYSTICK_X:   word = {20'b0, joyx_s2};
            cr_map_pkg::CR_JOYSTICK_Y:   word = {20'b0, joyy_s2};
            cr_map_pkg::CR_KBD_READY:    word = {31'b0, kbd_rdy_r};
            cr_map_pkg::CR_KBD_DATA:     word = {24'b0, kbd_data_r};
            default:                     word = '0;
        endcase
        return word;
    endfunction

    // Port A needs rden, port B reads every cycle
    always_comb begin
        pre_q   = rden ? read_word(address) : '0;
        pre_q_b = read_word(address_b);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q   <= '0;
            q_b <= '0;
        end else begin
            q   <= pre_q;
            q_b <= pre_q_b;
        end
    end

    // Reading the data register consumes the head byte
    assign kbd_pop = rden && (address == cr_map_pkg::CR_KBD_DATA);

endmodule

`default_nettype wire

// File: logic/cr_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module cr_subsystem_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Core port A
    input  cr_map_pkg::cr_addr_t address,
    input  cr_map_pkg::cr_data_t data,
    input  logic                 wren,
    input  logic                 rden,
    output cr_map_pkg::cr_data_t q,
    // Fabric port B
    input  cr_map_pkg::cr_addr_t address_b,
    output cr_map_pkg::cr_data_t q_b,
    // FPGA pins
    input  logic                 button_0,
    input  logic                 button_1,
    input  cr_map_pkg::switch_t  switch_in,
    input  cr_map_pkg::joy_t     joystick_x,
    input  cr_map_pkg::joy_t     joystick_y,
    output cr_map_pkg::seg7_t    seg7_0,
    output cr_map_pkg::seg7_t    seg7_1,
    output cr_map_pkg::seg7_t    seg7_2,
    output cr_map_pkg::seg7_t    seg7_3,
    output cr_map_pkg::seg7_t    seg7_4,
    output cr_map_pkg::seg7_t    seg7_5,
    output cr_map_pkg::led_t     led,
    // PS/2 lines
    input  logic                 kbd_clk,
    input  logic                 kbd_dat
);

    // Receiver to FIFO
    logic               push;
    kbd_pkg::kbd_byte_t push_byte;
    // FIFO to and from the register block
    logic               kbd_ready;
    kbd_pkg::kbd_byte_t kbd_head;
    logic               kbd_pop;
    logic               kbd_scanf_en;

    // ----------------------------------------------------------
    // Keyboard path
    // ----------------------------------------------------------
    kbd_ps2_rx u_ps2_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .kbd_clk      (kbd_clk),
        .kbd_dat      (kbd_dat),
        .kbd_scanf_en (kbd_scanf_en),
        .push         (push),
        .push_byte    (push_byte)
    );

    kbd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_kbd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_byte (push_byte),
        .kbd_pop   (kbd_pop),
        .kbd_ready (kbd_ready),
        .kbd_head  (kbd_head)
    );

    // ----------------------------------------------------------
    // Register block
    // ----------------------------------------------------------
    cr_mem u_cr_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .address      (address),
        .data         (data),
        .wren         (wren),
        .rden         (rden),
        .q            (q),
        .address_b    (address_b),
        .q_b          (q_b),
        .button_0     (button_0),
        .button_1     (button_1),
        .switch_in    (switch_in),
        .joystick_x   (joystick_x),
        .joystick_y   (joystick_y),
        .seg7_0       (seg7_0),
        .seg7_1       (seg7_1),
        .seg7_2       (seg7_2),
        .seg7_3       (seg7_3),
        .seg7_4       (seg7_4),
        .seg7_5       (seg7_5),
        .led          (led),
        .kbd_ready    (kbd_ready),
        .kbd_head     (kbd_head),
        .kbd_scanf_en (kbd_scanf_en),
        .kbd_pop      (kbd_pop)
    );

endmodule

`default_nettype wire

// File: logic/kbd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  kbd_pkg::kbd_byte_t push_byte,
    input  logic               kbd_pop,
    output logic               kbd_ready,
    output kbd_pkg::kbd_byte_t kbd_head
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    kbd_pkg::kbd_byte_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    // One extra bit so a full queue is distinct from empty
    logic [PTR_W:0]     count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full      = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign kbd_ready = (count != '0);

    // Push into full and pop of empty are both ignored
    assign do_push = push & ~full;
    assign do_pop  = kbd_pop & kbd_ready;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_byte;
        end
    end

    // Fall-through head
    assign kbd_head = mem[rd_ptr];

    // ----------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------
    // Depth is a power of two so pointers wrap by themselves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    // One scan code byte
    typedef logic [7:0] kbd_byte_t;

    // Start + 8 data + parity + stop
    localparam int PS2_FRAME_BITS = 11;

    // Receiver FSM
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        CHECK
    } ps2_state_t;

endpackage

`default_nettype wire

// File: logic/kbd_ps2_rx.sv
`timescale 1ns/1ps
`default_nettype none

module kbd_ps2_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               kbd_clk,
    input  logic               kbd_dat,
    input  logic               kbd_scanf_en,
    output logic               push,
    output kbd_pkg::kbd_byte_t push_byte
);

    localparam int FB    = kbd_pkg::PS2_FRAME_BITS;
    localparam int CNT_W = $clog2(FB + 1);

    // Two sync flops plus one history flop on the PS/2 clock
    logic [2:0]          clk_sync;
    logic [1:0]          dat_sync;
    logic                clk_fall;

    kbd_pkg::ps2_state_t state;
    logic [CNT_W-1:0]    bit_cnt;
    logic [FB-1:0]       frame;
    logic                frame_ok;
    logic                push_pend;

    // ----------------------------------------------------------
    // Line synchronizers
    // ----------------------------------------------------------
    // Idle PS/2 lines sit high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync <= '1;
            dat_sync <= '1;
        end else begin
            clk_sync <= {clk_sync[1:0], kbd_clk};
            dat_sync <= {dat_sync[0], kbd_dat};
        end
    end

    // Data changes on the rising edge and is sampled on the falling one
    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // ----------------------------------------------------------
    // Frame shifter
    // ----------------------------------------------------------
    // LSB first, so the start bit ends up in frame[0]
    always_ff @(posedge clk) begin
        if (clk_fall && (state != kbd_pkg::CHECK)) begin
            frame <= {dat_sync[1], frame[FB-1:1]};
        end
    end

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[FB-1] & (^frame[FB-2:1]);

    // ----------------------------------------------------------
    // Receiver FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= kbd_pkg::IDLE;
            bit_cnt   <= '0;
            push_pend <= 1'b0;
        end else begin
            push_pend <= 1'b0;
            case (state)
                kbd_pkg::IDLE: begin
                    // First falling edge carries the start bit
                    if (clk_fall) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= kbd_pkg::SHIFT;
                    end
                end
                kbd_pkg::SHIFT: begin
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // This edge samples the stop bit
                        if (bit_cnt == CNT_W'(FB - 1)) begin
                            state <= kbd_pkg::CHECK;
                        end
                    end
                end
                kbd_pkg::CHECK: begin
                    // Bad frames and frames finishing with scan off just fall back to idle
                    push_pend <= frame_ok & kbd_scanf_en;
                    state     <= kbd_pkg::IDLE;
                end
                default: state <= kbd_pkg::IDLE;
            endcase
        end
    end

    // Byte held stable for the push cycle
    always_ff @(posedge clk) begin
        if (state == kbd_pkg::CHECK) begin
            push_byte <= frame[8:1];
        end
    end

    // One-cycle push strobe
    assign push = push_pend;

endmodule

`default_nettype wire

// File: src.f
logic/cr_map_pkg.sv
logic/kbd_pkg.sv
logic/kbd_ps2_rx.sv
logic/kbd_fifo.sv
logic/cr_mem.sv
logic/cr_subsystem_top.sv
verification/cr_subsystem_assert.sv
verification/cr_subsystem_tb.sv

// File: verification/cr_subsystem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cr_subsystem_assert (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 rden,
    input  cr_map_pkg::cr_data_t q,
    input  logic                 kbd_pop,
    input  logic                 push,
    input  logic                 kbd_scanf_en
);

    // Failure tally
    int assert_errors = 0;

    // ----------------------------------------------------------
    // Keyboard queue protocol
    // ----------------------------------------------------------
    // Data reads are spaced, so pops never touch
    pop_single: assert property (@(posedge clk) disable iff (!rst_n)
        kbd_pop |=> !kbd_pop)
        else begin
            $error("kbd_pop high in two consecutive cycles");
            assert_errors++;
        end

    // Receiver stays quiet while scan is off
    push_needs_scan: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> kbd_scanf_en)
        else begin
            $error("push while kbd_scanf_en is low");
            assert_errors++;
        end

    // ----------------------------------------------------------
    // Core read port
    // ----------------------------------------------------------
    q_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !rden |=> (q == '0))
        else begin
            $error("q not zero after a cycle without rden");
            assert_errors++;
        end

endmodule

bind cr_subsystem_top cr_subsystem_assert u_cr_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .rden         (rden),
    .q            (q),
    .kbd_pop      (kbd_pop),
    .push         (push),
    .kbd_scanf_en (kbd_scanf_en)
);

`default_nettype wire

// File: verification/cr_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cr_subsystem_tb;

    // ----------------------------------------------------------
    // Run length
    // ----------------------------------------------------------
    localparam int FIFO_DEPTH      = 4;
    // System cycles per PS/2 clock half period
    localparam int HALF_BIT        = 8;
    // 3 in order, 2 dropped, 6 into the small queue
    localparam int NUM_FRAMES      = 11;
    localparam int FRAME_CYCLES    = kbd_pkg::PS2_FRAME_BITS * 2 * HALF_BIT + HALF_BIT;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 2 + 2000;
    localparam int READY_POLLS     = 64;

    logic                 clk;
    logic                 rst_n;
    cr_map_pkg::cr_addr_t address;
    cr_map_pkg::cr_data_t data;
    logic                 wren;
    logic                 rden;
    cr_map_pkg::cr_data_t q;
    cr_map_pkg::cr_addr_t address_b;
    cr_map_pkg::cr_data_t q_b;
    logic                 button_0;
    logic                 button_1;
    cr_map_pkg::switch_t  switch_in;
    cr_map_pkg::joy_t     joystick_x;
    cr_map_pkg::joy_t     joystick_y;
    cr_map_pkg::seg7_t    seg7_0;
    cr_map_pkg::seg7_t    seg7_1;
    cr_map_pkg::seg7_t    seg7_2;
    cr_map_pkg::seg7_t    seg7_3;
    cr_map_pkg::seg7_t    seg7_4;
    cr_map_pkg::seg7_t    seg7_5;
    cr_map_pkg::led_t     led;
    logic                 kbd_clk;
    logic                 kbd_dat;

    int                   errors;
    int                   checks;
    integer               seed;

    cr_subsystem_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data       (data),
        .wren       (wren),
        .rden       (rden),
        .q          (q),
        .address_b  (address_b),
        .q_b        (q_b),
        .button_0   (button_0),
        .button_1   (button_1),
        .switch_in  (switch_in),
        .joystick_x (joystick_x),
        .joystick_y (joystick_y),
        .seg7_0     (seg7_0),
        .seg7_1     (seg7_1),
        .seg7_2     (seg7_2),
        .seg7_3     (seg7_3),
        .seg7_4     (seg7_4),
        .seg7_5     (seg7_5),
        .led        (led),
        .kbd_clk    (kbd_clk),
        .kbd_dat    (kbd_dat)
    );

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Ends a stuck run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Register map helpers
    // ----------------------------------------------------------
    // Read/write registers by index, seven-segment first
    function automatic cr_map_pkg::cr_addr_t rw_offset(input int idx);
        case (idx)
            0:       return cr_map_pkg::CR_SEG7_0;
            1:       return cr_map_pkg::CR_SEG7_1;
            2:       return cr_map_pkg::CR_SEG7_2;
            3:       return cr_map_pkg::CR_SEG7_3;
            4:       return cr_map_pkg::CR_SEG7_4;
            5:       return cr_map_pkg::CR_SEG7_5;
            6:       return cr_map_pkg::CR_LED;
            default: return cr_map_pkg::CR_KBD_SCANF_EN;
        endcase
    endfunction

    // Field width of each register
    function automatic cr_map_pkg::cr_data_t rw_mask(input int idx);
        if (idx < 6) begin
            return 32'h0000_00FF;
        end else if (idx == 6) begin
            return 32'h0000_03FF;
        end
        return 32'h0000_0001;
    endfunction

    function automatic cr_map_pkg::cr_data_t pin_value(input int idx);
        case (idx)
            0:       return {24'b0, seg7_0};
            1:       return {24'b0, seg7_1};
            2:       return {24'b0, seg7_2};
            3:       return {24'b0, seg7_3};
            4:       return {24'b0, seg7_4};
            5:       return {24'b0, seg7_5};
            default: return {22'b0, led};
        endcase
    endfunction

    task automatic check_value(input string name, input cr_map_pkg::cr_data_t expected,
                               input cr_map_pkg::cr_data_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // ----------------------------------------------------------
    // Bus access, all on the falling edge
    // ----------------------------------------------------------
    task automatic write_reg(input cr_map_pkg::cr_addr_t addr,
                             input cr_map_pkg::cr_data_t value);
        address = addr;
        data    = value;
        wren    = 1'b1;
        @(negedge clk);
        wren    = 1'b0;
        data    = '0;
    endtask

    // One read on both ports, then an idle cycle to space keyboard pops
    task automatic read_both(input cr_map_pkg::cr_addr_t addr,
                             output cr_map_pkg::cr_data_t q_val,
                             output cr_map_pkg::cr_data_t qb_val);
        address   = addr;
        address_b = addr;
        rden      = 1'b1;
        @(negedge clk);
        q_val     = q;
        qb_val    = q_b;
        rden      = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_and_compare(input string name, input cr_map_pkg::cr_addr_t addr,
                                    input cr_map_pkg::cr_data_t expected);
        cr_map_pkg::cr_data_t q_val;
        cr_map_pkg::cr_data_t qb_val;
        read_both(addr, q_val, qb_val);
        check_value({name, " q"}, expected, q_val);
        check_value({name, " q_b"}, expected, qb_val);
    endtask

    // Polls the ready register until a byte is queued
    task automatic wait_kbd_ready();
        cr_map_pkg::cr_data_t q_val;
        cr_map_pkg::cr_data_t qb_val;
        int                   polls;
        polls = 0;
        q_val = '0;
        while (q_val[0] !== 1'b1 && polls < READY_POLLS) begin
            read_both(cr_map_pkg::CR_KBD_READY, q_val, qb_val);
            polls++;
        end
        if (q_val[0] !== 1'b1) begin
            $display("Keyboard ready did not rise within %0d polls", READY_POLLS);
            errors++;
        end
    endtask

    // ----------------------------------------------------------
    // PS/2 frame driver
    // ----------------------------------------------------------
    // Start, 8 data LSB first, parity, stop
    task automatic ps2_send(input kbd_pkg::kbd_byte_t value, input bit good_parity);
        logic [kbd_pkg::PS2_FRAME_BITS-1:0] bits;
        logic                               par;
        // Odd parity over data plus parity bit
        par  = good_parity ? ~(^value) : (^value);
        bits = {1'b1, par, value, 1'b0};
        for (int i = 0; i < kbd_pkg::PS2_FRAME_BITS; i++) begin
            kbd_dat = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            kbd_clk = 1'b0;
            repeat (HALF_BIT) @(negedge clk);
            kbd_clk = 1'b1;
        end
        kbd_dat = 1'b1;
        repeat (HALF_BIT) @(negedge clk);
    endtask

    // ----------------------------------------------------------
    // Tests
    // ----------------------------------------------------------
    initial begin
        cr_map_pkg::cr_data_t wr_val;
        cr_map_pkg::cr_data_t exp_val;
        cr_map_pkg::cr_data_t rnd;
        kbd_pkg::kbd_byte_t   sent [$];

        errors     = 0;
        checks     = 0;
        seed       = 32'h9d54_23e9;
        rst_n      = 1'b0;
        address    = '0;
        data       = '0;
        wren       = 1'b0;
        rden       = 1'b0;
        address_b  = '0;
        button_0   = 1'b0;
        button_1   = 1'b0;
        switch_in  = '0;
        joystick_x = '0;
        joystick_y = '0;
        // Idle PS/2 lines are high
        kbd_clk    = 1'b1;
        kbd_dat    = 1'b1;
        repeat (3) @(negedge clk);
        rst_n      = 1'b1;

        // Reset values
        check_value("reset q", '0, q);
        check_value("reset q_b", '0, q_b);
        for (int i = 0; i < 7; i++) begin
            check_value($sformatf("reset pin %0d", i), '0, pin_value(i));
        end
        check_value("reset scan enable", '0, {31'b0, DUT.kbd_scanf_en});

        // Random writes, masked readback, pins two cycles later
        for (int i = 0; i < 8; i++) begin
            wr_val  = $random(seed);
            exp_val = wr_val & rw_mask(i);
            write_reg(rw_offset(i), wr_val);
            repeat (2) @(negedge clk);
            if (i < 7) begin
                check_value($sformatf("pin %0d", i), exp_val, pin_value(i));
            end
            read_and_compare($sformatf("readback %0d", i), rw_offset(i), exp_val);
        end

        // Board inputs held for more than the sync depth
        for (int r = 0; r < 2; r++) begin
            rnd        = $random(seed);
            button_0   = rnd[0];
            button_1   = rnd[1];
            switch_in  = rnd[11:2];
            joystick_x = rnd[23:12];
            rnd        = $random(seed);
            joystick_y = rnd[11:0];
            repeat (4) @(negedge clk);
            read_and_compare("button_0", cr_map_pkg::CR_BUTTON_0, {31'b0, button_0});
            read_and_compare("button_1", cr_map_pkg::CR_BUTTON_1, {31'b0, button_1});
            read_and_compare("switch", cr_map_pkg::CR_SWITCH, {22'b0, switch_in});
            read_and_compare("joystick_x", cr_map_pkg::CR_JOYSTICK_X, {20'b0, joystick_x});
            read_and_compare("joystick_y", cr_map_pkg::CR_JOYSTICK_Y, {20'b0, joystick_y});
        end
        read_and_compare("unmapped 0x3c", 32'h0000_003C, '0);
        read_and_compare("unmapped 0x40", 32'h0000_0040, '0);
        read_and_compare("unmapped 0x02", 32'h0000_0002, '0);
        read_and_compare("unmapped top", 32'hFFFF_FFFC, '0);

        // Three good frames come back in order
        write_reg(cr_map_pkg::CR_KBD_SCANF_EN, 32'h1);
        for (int f = 0; f < 3; f++) begin
            rnd = $random(seed);
            sent.push_back(rnd[7:0]);
            ps2_send(rnd[7:0], 1'b1);
        end
        wait_kbd_ready();
        while (sent.size() > 0) begin
            read_and_compare("kbd data", cr_map_pkg::CR_KBD_DATA, {24'b0, sent.pop_front()});
        end
        read_and_compare("kbd ready after drain", cr_map_pkg::CR_KBD_READY, '0);

        // Bad parity, then a good frame with scan off
        ps2_send(8'hA5, 1'b0);
        write_reg(cr_map_pkg::CR_KBD_SCANF_EN, 32'h0);
        ps2_send(8'h3C, 1'b1);
        read_and_compare("kbd ready after drops", cr_map_pkg::CR_KBD_READY, '0);

        // Six frames into a depth-4 queue keep the first four
        write_reg(cr_map_pkg::CR_KBD_SCANF_EN, 32'h1);
        for (int f = 0; f < 6; f++) begin
            rnd = $random(seed);
            if (f < FIFO_DEPTH) begin
                sent.push_back(rnd[7:0]);
            end
            ps2_send(rnd[7:0], 1'b1);
        end
        wait_kbd_ready();
        while (sent.size() > 0) begin
            read_and_compare("kbd overflow data", cr_map_pkg::CR_KBD_DATA,
                             {24'b0, sent.pop_front()});
        end
        read_and_compare("kbd ready after overflow", cr_map_pkg::CR_KBD_READY, '0);

        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d, assertion errors: %0d",
                 checks, errors, DUT.u_cr_assert.assert_errors);
        if (errors == 0 && DUT.u_cr_assert.assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
